/* id_ctrl_pkg.sv */
package id_ctrl_pkg;

    // ======================================================================
    // operation handed to execute
    // ======================================================================
    typedef enum logic [4:0] {
        EX_NOP,
        EX_ADD,
        EX_SUB,
        EX_SLT,
        EX_SLTU,
        EX_AND,
        EX_OR,
        EX_XOR,
        EX_SLL,
        EX_SRL,
        EX_SRA,
        EX_LB,
        EX_LH,
        EX_LW,
        EX_LBU,
        EX_LHU,
        EX_SB,
        EX_SH,
        EX_SW
    } alu_op_e;

    // result class, picks the execute output mux.
    typedef enum logic [2:0] {
        RES_NOP,
        RES_LOGIC,
        RES_ARITH,
        RES_SHIFT,
        RES_LD_ST
    } alu_sel_e;

endpackage

/* id_decoder.sv */
`timescale 1ns/1ps

module id_decoder import rv_isa_pkg::*, id_ctrl_pkg::*; (
    id_fields_if.dst fields,
    id_decode_if.src dec
);

    alu_op_e  op;
    alu_sel_e sel;
    logic     rd1;
    logic     rd2;
    word_t    imm_sel;
    logic     valid;

    // ======================================================================
    // operation, read enables and immediate per opcode
    // ======================================================================
    always_comb begin
        op      = EX_NOP;
        rd1     = 1'b0;
        rd2     = 1'b0;
        imm_sel = '0;
        case (fields.opcode)
            OP_OP: begin
                rd1 = 1'b1;
                rd2 = 1'b1;
                case (fields.funct3)
                    F3_ADD: begin
                        if (fields.funct7 == F7_BASE) op = EX_ADD;
                        else if (fields.funct7 == F7_ALT) op = EX_SUB;
                    end
                    F3_SLT:  op = EX_SLT;
                    F3_SLTU: op = EX_SLTU;
                    F3_AND:  op = EX_AND;
                    F3_OR:   op = EX_OR;
                    F3_XOR:  op = EX_XOR;
                    F3_SLL:  op = EX_SLL;
                    F3_SRL: begin
                        if (fields.funct7 == F7_BASE) op = EX_SRL;
                        else if (fields.funct7 == F7_ALT) op = EX_SRA;
                    end
                    default: op = EX_NOP;
                endcase
            end
            OP_OPI: begin
                rd1     = 1'b1;
                imm_sel = fields.imm_i;
                case (fields.funct3)
                    F3_ADD:  op = EX_ADD;
                    F3_SLT:  op = EX_SLT;
                    F3_SLTU: op = EX_SLTU;
                    F3_AND:  op = EX_AND;
                    F3_OR:   op = EX_OR;
                    F3_XOR:  op = EX_XOR;
                    F3_SLL: begin
                        op      = EX_SLL;
                        imm_sel = fields.shamt;
                    end
                    F3_SRL: begin
                        imm_sel = fields.shamt;
                        if (fields.funct7 == F7_BASE) op = EX_SRL;
                        else if (fields.funct7 == F7_ALT) op = EX_SRA;
                    end
                    default: op = EX_NOP;
                endcase
            end
            OP_LOAD: begin
                rd1     = 1'b1;
                imm_sel = fields.imm_i;  // address offset.
                case (fields.funct3)
                    F3_LB:   op = EX_LB;
                    F3_LH:   op = EX_LH;
                    F3_LW:   op = EX_LW;
                    F3_LBU:  op = EX_LBU;
                    F3_LHU:  op = EX_LHU;
                    default: op = EX_NOP;
                endcase
            end
            OP_STORE: begin
                rd1     = 1'b1;
                rd2     = 1'b1;          // rs2 holds the store data.
                imm_sel = fields.imm_s;
                case (fields.funct3)
                    F3_SB:   op = EX_SB;
                    F3_SH:   op = EX_SH;
                    F3_SW:   op = EX_SW;
                    default: op = EX_NOP;
                endcase
            end
            OP_LUI: begin
                op      = EX_OR;         // both operands carry the upper immediate.
                imm_sel = fields.imm_u;
            end
            default: op = EX_NOP;
        endcase
    end

    // result class follows from the operation.
    always_comb begin
        case (op)
            EX_AND, EX_OR, EX_XOR:           sel = RES_LOGIC;
            EX_ADD, EX_SUB, EX_SLT, EX_SLTU: sel = RES_ARITH;
            EX_SLL, EX_SRL, EX_SRA:          sel = RES_SHIFT;
            EX_NOP:                          sel = RES_NOP;
            default:                         sel = RES_LD_ST;
        endcase
    end

    // an undecoded word turns into a bubble.
    assign valid = (op != EX_NOP);

    assign dec.aluop      = op;
    assign dec.alusel     = sel;
    assign dec.inst_valid = valid;
    assign dec.wreg       = valid && (fields.opcode != OP_STORE);
    assign dec.wd         = valid ? fields.rd : '0;
    assign dec.reg1_read  = valid && rd1;
    assign dec.reg2_read  = valid && rd2;
    assign dec.reg1_addr  = fields.rs1;
    assign dec.reg2_addr  = fields.rs2;
    assign dec.imm        = valid ? imm_sel : '0;

endmodule

/* id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import rv_isa_pkg::*, id_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    id_decode_if.dst  dec,
    input  word_t     reg1_val_i,
    input  word_t     reg2_val_i,
    input  logic      stall_i,
    output alu_op_e   ex_aluop_o,
    output alu_sel_e  ex_alusel_o,
    output word_t     ex_reg1_o,
    output word_t     ex_reg2_o,
    output word_t     ex_offset_o,
    output reg_addr_t ex_wd_o,
    output logic      ex_wreg_o,
    output logic      ex_inst_valid_o
);

    // ======================================================================
    // decode/execute boundary
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset_i || stall_i) begin
            // bubble, execute sees a nop with no write.
            ex_aluop_o      <= EX_NOP;
            ex_alusel_o     <= RES_NOP;
            ex_reg1_o       <= '0;
            ex_reg2_o       <= '0;
            ex_offset_o     <= '0;
            ex_wd_o         <= '0;
            ex_wreg_o       <= 1'b0;
            ex_inst_valid_o <= 1'b0;
        end else begin
            ex_aluop_o      <= dec.aluop;
            ex_alusel_o     <= dec.alusel;
            ex_reg1_o       <= reg1_val_i;
            ex_reg2_o       <= reg2_val_i;
            ex_offset_o     <= dec.imm;      // load/store offset.
            ex_wd_o         <= dec.wd;
            ex_wreg_o       <= dec.wreg;
            ex_inst_valid_o <= dec.inst_valid;
        end
    end

endmodule

/* id_ifaces.sv */
`timescale 1ns/1ps

// split instruction from the buffer into the decoder.
interface id_fields_if import rv_isa_pkg::*; ();

    opcode_t   opcode;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    funct3_t   funct3;
    funct7_t   funct7;
    word_t     imm_i;   // sign extended.
    word_t     imm_s;   // sign extended.
    word_t     imm_u;   // low 12 bits zero.
    word_t     shamt;   // rs2 field, zero extended.

    modport src (
        output opcode, rd, rs1, rs2, funct3, funct7,
        output imm_i, imm_s, imm_u, shamt
    );

    modport dst (
        input opcode, rd, rs1, rs2, funct3, funct7,
        input imm_i, imm_s, imm_u, shamt
    );

endinterface

// decode result, read by operand select and the d/e register.
interface id_decode_if import rv_isa_pkg::*, id_ctrl_pkg::*; ();

    alu_op_e   aluop;
    alu_sel_e  alusel;
    reg_addr_t wd;
    logic      wreg;
    logic      inst_valid;
    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    word_t     imm;

    modport src (
        output aluop, alusel, wd, wreg, inst_valid,
        output reg1_read, reg2_read, reg1_addr, reg2_addr, imm
    );

    modport dst (
        input aluop, alusel, wd, wreg, inst_valid,
        input reg1_read, reg2_read, reg1_addr, reg2_addr, imm
    );

endinterface

/* id_inst_buffer.sv */
`timescale 1ns/1ps

module id_inst_buffer import rv_isa_pkg::*; (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           hold_i,
    input  inst_t          inst_i,
    id_fields_if.src       fields
);

    inst_t inst_q;

    // ======================================================================
    // instruction register
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_q <= NOP_INST;
        end else if (!hold_i) begin
            inst_q <= inst_i;
        end
        // on hold the word waits for the load-use hazard to clear.
    end

    // ======================================================================
    // field split
    // ======================================================================
    assign fields.opcode = inst_q[6:0];
    assign fields.rd     = inst_q[11:7];
    assign fields.funct3 = inst_q[14:12];
    assign fields.rs1    = inst_q[19:15];
    assign fields.rs2    = inst_q[24:20];
    assign fields.funct7 = inst_q[31:25];

    // i-type, bits 31:20.
    assign fields.imm_i = {{20{inst_q[31]}}, inst_q[31:20]};

    // s-type, offset split around rd.
    assign fields.imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};

    assign fields.imm_u = {inst_q[31:12], 12'h000};  // lui.
    assign fields.shamt = {27'h0, inst_q[24:20]};    // shift amount.

endmodule

/* id_operand_sel.sv */
`timescale 1ns/1ps

module id_operand_sel import rv_isa_pkg::*; (
    id_decode_if.dst dec,
    input  word_t     reg1_data_i,
    input  word_t     reg2_data_i,
    input  logic      ex_ld_flag_i,
    input  logic      ex_wreg_i,
    input  word_t     ex_wdata_i,
    input  reg_addr_t ex_wd_i,
    input  logic      mem_wreg_i,
    input  word_t     mem_wdata_i,
    input  reg_addr_t mem_wd_i,
    output word_t     reg1_val_o,
    output word_t     reg2_val_o,
    output logic      stall_o
);

    logic stall1;
    logic stall2;

    // ======================================================================
    // forwarding for one operand, nearest stage first
    // ======================================================================
    function automatic void pick_operand(
        input  logic      rd_en,
        input  reg_addr_t addr,
        input  word_t     rf_data,
        input  word_t     imm,
        output word_t     val,
        output logic      stall
    );
        stall = 1'b0;
        val   = rf_data;
        if (!rd_en) begin
            val = imm;                   // unread slot carries the immediate.
        end else if (ex_ld_flag_i && (ex_wd_i == addr)) begin
            val   = '0;                  // load data not back yet.
            stall = 1'b1;
        end else if (ex_wreg_i && (ex_wd_i == addr)) begin
            val = ex_wdata_i;
        end else if (mem_wreg_i && (mem_wd_i == addr)) begin
            val = mem_wdata_i;
        end
    endfunction

    always_comb begin
        pick_operand(dec.reg1_read, dec.reg1_addr, reg1_data_i, dec.imm,
                     reg1_val_o, stall1);
    end

    always_comb begin
        pick_operand(dec.reg2_read, dec.reg2_addr, reg2_data_i, dec.imm,
                     reg2_val_o, stall2);
    end

    assign stall_o = stall1 | stall2;  // load-use on either source.

endmodule

/* id_stage.f */
rv_isa_pkg.sv
id_ctrl_pkg.sv
id_ifaces.sv
id_inst_buffer.sv
id_decoder.sv
id_operand_sel.sv
id_ex_reg.sv
id_stage.sv
id_stage_chk.sv
tb_id_stage.sv

/* id_stage.sv */
`timescale 1ns/1ps

module id_stage import rv_isa_pkg::*, id_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  inst_t     inst_i,
    // register file read ports.
    input  word_t     reg1_data_i,
    input  word_t     reg2_data_i,
    output logic      reg1_read_o,
    output logic      reg2_read_o,
    output reg_addr_t reg1_addr_o,
    output reg_addr_t reg2_addr_o,
    // forwarding from execute and memory.
    input  logic      ex_ld_flag_i,
    input  logic      ex_wreg_i,
    input  word_t     ex_wdata_i,
    input  reg_addr_t ex_wd_i,
    input  logic      mem_wreg_i,
    input  word_t     mem_wdata_i,
    input  reg_addr_t mem_wd_i,
    output logic      stall_req_o,
    // to execute.
    output alu_op_e   ex_aluop_o,
    output alu_sel_e  ex_alusel_o,
    output word_t     ex_reg1_o,
    output word_t     ex_reg2_o,
    output word_t     ex_offset_o,
    output reg_addr_t ex_wd_o,
    output logic      ex_wreg_o,
    output logic      ex_inst_valid_o
);

    word_t reg1_val;
    word_t reg2_val;
    logic  stall;

    id_fields_if fields_if ();
    id_decode_if dec_if ();

    // ======================================================================
    // stage instances
    // ======================================================================
    id_inst_buffer i_buffer (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (stall),
        .inst_i  (inst_i),
        .fields  (fields_if.src)
    );

    id_decoder i_decoder (
        .fields (fields_if.dst),
        .dec    (dec_if.src)
    );

    id_operand_sel i_operand_sel (
        .dec          (dec_if.dst),
        .reg1_data_i  (reg1_data_i),
        .reg2_data_i  (reg2_data_i),
        .ex_ld_flag_i (ex_ld_flag_i),
        .ex_wreg_i    (ex_wreg_i),
        .ex_wdata_i   (ex_wdata_i),
        .ex_wd_i      (ex_wd_i),
        .mem_wreg_i   (mem_wreg_i),
        .mem_wdata_i  (mem_wdata_i),
        .mem_wd_i     (mem_wd_i),
        .reg1_val_o   (reg1_val),
        .reg2_val_o   (reg2_val),
        .stall_o      (stall)
    );

    id_ex_reg i_ex_reg (
        .clk             (clk),
        .reset_i         (reset_i),
        .dec             (dec_if.dst),
        .reg1_val_i      (reg1_val),
        .reg2_val_i      (reg2_val),
        .stall_i         (stall),
        .ex_aluop_o      (ex_aluop_o),
        .ex_alusel_o     (ex_alusel_o),
        .ex_reg1_o       (ex_reg1_o),
        .ex_reg2_o       (ex_reg2_o),
        .ex_offset_o     (ex_offset_o),
        .ex_wd_o         (ex_wd_o),
        .ex_wreg_o       (ex_wreg_o),
        .ex_inst_valid_o (ex_inst_valid_o)
    );

    // register file reads leave straight from the buffered word.
    assign reg1_read_o = dec_if.reg1_read;
    assign reg2_read_o = dec_if.reg2_read;
    assign reg1_addr_o = dec_if.reg1_addr;
    assign reg2_addr_o = dec_if.reg2_addr;
    assign stall_req_o = stall;

endmodule

/* id_stage_chk.sv */
`timescale 1ns/1ps

module id_stage_chk import id_ctrl_pkg::*; (
    input logic    clk,
    input logic    reset_i,
    input logic    stall_i,
    input logic    wreg_i,
    input logic    valid_i,
    input alu_op_e aluop_i
);

    // ======================================================================
    // decode/execute boundary rules
    // ======================================================================
    stall_bubble: assert property (
        @(posedge clk) disable iff (reset_i) stall_i |=> (!wreg_i && !valid_i)
    ) else $error("stall was not followed by a bubble");

    // stores never write the register file.
    store_no_write: assert property (
        @(posedge clk) disable iff (reset_i)
            !(wreg_i && (aluop_i inside {EX_SB, EX_SH, EX_SW}))
    ) else $error("store operation with register write enabled");

    reset_idle: assert property (
        @(posedge clk) reset_i |=> (!wreg_i && !valid_i && !stall_i)
    ) else $error("outputs active after reset");

endmodule

bind id_stage id_stage_chk i_chk (
    .clk     (clk),
    .reset_i (reset_i),
    .stall_i (stall_req_o),
    .wreg_i  (ex_wreg_o),
    .valid_i (ex_inst_valid_o),
    .aluop_i (ex_aluop_o)
);

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_id_stage -f id_stage.f \
    && ./obj_dir/Vtb_id_stage | tee /dev/stderr | grep -qx "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // ======================================================================
    // RV32I word and field types
    // ======================================================================
    typedef logic [31:0] word_t;       // data word, operands and immediates.
    typedef logic [31:0] inst_t;       // raw instruction word.
    typedef logic [4:0]  reg_addr_t;   // register index.
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // ======================================================================
    // major opcodes
    // ======================================================================
    localparam opcode_t OP_LOAD  = 7'b000_0011;
    localparam opcode_t OP_STORE = 7'b010_0011;
    localparam opcode_t OP_OP    = 7'b011_0011;
    localparam opcode_t OP_OPI   = 7'b001_0011;
    localparam opcode_t OP_LUI   = 7'b011_0111;

    // funct3 of OP and OP-IMM.
    localparam funct3_t F3_ADD  = 3'b000;  // add, sub, addi.
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101;  // srl and sra share it.
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct3 of loads and stores.
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

    localparam funct7_t F7_BASE = 7'b000_0000;
    localparam funct7_t F7_ALT  = 7'b010_0000;  // selects sub and sra.

    localparam inst_t NOP_INST = 32'h0000_0013;  // addi x0, x0, 0.

endpackage

/* tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage import rv_isa_pkg::*, id_ctrl_pkg::*; ();

    localparam int    CLK_PERIOD  = 8;
    localparam int    RESET_CYCLES = 10;
    localparam word_t EXD     = 32'heeee0001;  // execute-stage result.
    localparam word_t MEMD    = 32'hdddd0002;  // memory-stage result.
    localparam word_t LUI_IMM = 32'h12345000;

    // fwd is {ld_flag, ex_wreg, mem_wreg, source address}, flags is {rd1, rd2, wreg, valid, stall}.
    typedef struct packed {
        inst_t     inst;
        logic [7:0] fwd;
        alu_op_e   op;
        alu_sel_e  sel;
        word_t     r1;
        word_t     r2;
        word_t     off;
        reg_addr_t wd;
        logic [4:0] flags;
    } row_t;

    logic clk;
    logic reset_i;
    inst_t inst_i;
    word_t reg1_data, reg2_data;
    logic reg1_read, reg2_read;
    reg_addr_t reg1_addr, reg2_addr;
    logic ex_ld_flag_i, ex_wreg_i, mem_wreg_i;
    word_t ex_wdata_i, mem_wdata_i;
    reg_addr_t ex_wd_i, mem_wd_i;
    logic stall_req_o;
    alu_op_e ex_aluop_o;
    alu_sel_e ex_alusel_o;
    word_t ex_reg1_o, ex_reg2_o, ex_offset_o;
    reg_addr_t ex_wd_o;
    logic ex_wreg_o, ex_inst_valid_o;

    row_t  rows[$];
    string names[$];
    int    errors = 0;
    int    checks = 0;

    id_stage i_dut (
        .clk (clk), .reset_i (reset_i), .inst_i (inst_i),
        .reg1_data_i (reg1_data), .reg2_data_i (reg2_data),
        .reg1_read_o (reg1_read), .reg2_read_o (reg2_read),
        .reg1_addr_o (reg1_addr), .reg2_addr_o (reg2_addr),
        .ex_ld_flag_i (ex_ld_flag_i), .ex_wreg_i (ex_wreg_i),
        .ex_wdata_i (ex_wdata_i), .ex_wd_i (ex_wd_i),
        .mem_wreg_i (mem_wreg_i), .mem_wdata_i (mem_wdata_i), .mem_wd_i (mem_wd_i),
        .stall_req_o (stall_req_o),
        .ex_aluop_o (ex_aluop_o), .ex_alusel_o (ex_alusel_o),
        .ex_reg1_o (ex_reg1_o), .ex_reg2_o (ex_reg2_o), .ex_offset_o (ex_offset_o),
        .ex_wd_o (ex_wd_o), .ex_wreg_o (ex_wreg_o), .ex_inst_valid_o (ex_inst_valid_o)
    );

    // register file model, same-cycle read.
    function automatic word_t rf(input reg_addr_t a);
        return 32'h1000_0000 + {27'h0, a};
    endfunction

    assign reg1_data = rf(reg1_addr);
    assign reg2_data = rf(reg2_addr);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_row(input string name, input inst_t inst, input logic [7:0] fwd,
                           input alu_op_e op, input alu_sel_e sel, input word_t r1,
                           input word_t r2, input word_t off, input reg_addr_t wd,
                           input logic [4:0] flags);
        row_t r;
        r = '{inst, fwd, op, sel, r1, r2, off, wd, flags};
        rows.push_back(r);
        names.push_back(name);
    endtask

    // ======================================================================
    // stimulus and expected values
    // ======================================================================
    task automatic load_table();
        add_row("add",  32'h003100b3, 8'h00, EX_ADD,  RES_ARITH, rf(2), rf(3), 0, 5'd1, 5'b11110);
        add_row("sub",  32'h403100b3, 8'h00, EX_SUB,  RES_ARITH, rf(2), rf(3), 0, 5'd1, 5'b11110);
        add_row("slt",  32'h003120b3, 8'h00, EX_SLT,  RES_ARITH, rf(2), rf(3), 0, 5'd1, 5'b11110);
        add_row("and",  32'h003170b3, 8'h00, EX_AND,  RES_LOGIC, rf(2), rf(3), 0, 5'd1, 5'b11110);
        add_row("or",   32'h003160b3, 8'h00, EX_OR,   RES_LOGIC, rf(2), rf(3), 0, 5'd1, 5'b11110);
        add_row("xor",  32'h003140b3, 8'h00, EX_XOR,  RES_LOGIC, rf(2), rf(3), 0, 5'd1, 5'b11110);
        add_row("sll",  32'h003110b3, 8'h00, EX_SLL,  RES_SHIFT, rf(2), rf(3), 0, 5'd1, 5'b11110);
        add_row("srl",  32'h003150b3, 8'h00, EX_SRL,  RES_SHIFT, rf(2), rf(3), 0, 5'd1, 5'b11110);
        add_row("sra",  32'h403150b3, 8'h00, EX_SRA,  RES_SHIFT, rf(2), rf(3), 0, 5'd1, 5'b11110);
        add_row("addi", 32'hff828213, 8'h00, EX_ADD,  RES_ARITH, rf(5), -8, -8, 5'd4, 5'b10110);
        add_row("ori",  32'hfff2e213, 8'h00, EX_OR,   RES_LOGIC, rf(5), -1, -1, 5'd4, 5'b10110);
        add_row("slti", 32'h8002a213, 8'h00, EX_SLT,  RES_ARITH, rf(5), -2048, -2048,
                5'd4, 5'b10110);
        add_row("slli", 32'h00329213, 8'h00, EX_SLL,  RES_SHIFT, rf(5), 3, 3, 5'd4, 5'b10110);
        add_row("srli", 32'h0072d213, 8'h00, EX_SRL,  RES_SHIFT, rf(5), 7, 7, 5'd4, 5'b10110);
        add_row("srai", 32'h4072d213, 8'h00, EX_SRA,  RES_SHIFT, rf(5), 7, 7, 5'd4, 5'b10110);
        add_row("lui",  32'h12345337, 8'h00, EX_OR,   RES_LOGIC, LUI_IMM, LUI_IMM, LUI_IMM,
                5'd6, 5'b00110);
        add_row("lb",   32'hffc40383, 8'h00, EX_LB,   RES_LD_ST, rf(8), -4, -4, 5'd7, 5'b10110);
        add_row("lh",   32'hffc41383, 8'h00, EX_LH,   RES_LD_ST, rf(8), -4, -4, 5'd7, 5'b10110);
        add_row("lw",   32'hffc42383, 8'h00, EX_LW,   RES_LD_ST, rf(8), -4, -4, 5'd7, 5'b10110);
        add_row("lbu",  32'hffc44383, 8'h00, EX_LBU,  RES_LD_ST, rf(8), -4, -4, 5'd7, 5'b10110);
        add_row("lhu",  32'hffc45383, 8'h00, EX_LHU,  RES_LD_ST, rf(8), -4, -4, 5'd7, 5'b10110);
        // rd field of a store holds offset bits 4:0.
        add_row("sb",   32'hfea48623, 8'h00, EX_SB,   RES_LD_ST, rf(9), rf(10), -20,
                5'd12, 5'b11010);
        add_row("sh",   32'hfea49623, 8'h00, EX_SH,   RES_LD_ST, rf(9), rf(10), -20,
                5'd12, 5'b11010);
        add_row("sw",   32'hfea4a623, 8'h00, EX_SW,   RES_LD_ST, rf(9), rf(10), -20,
                5'd12, 5'b11010);
        add_row("fwd_ex_rs1",  32'h003100b3, 8'h62, EX_ADD, RES_ARITH, EXD, rf(3), 0,
                5'd1, 5'b11110);
        add_row("fwd_mem_rs1", 32'h003100b3, 8'h22, EX_ADD, RES_ARITH, MEMD, rf(3), 0,
                5'd1, 5'b11110);
        add_row("fwd_ex_rs2",  32'h003100b3, 8'h63, EX_ADD, RES_ARITH, rf(2), EXD, 0,
                5'd1, 5'b11110);
        add_row("fwd_mem_rs2", 32'h003100b3, 8'h23, EX_ADD, RES_ARITH, rf(2), MEMD, 0,
                5'd1, 5'b11110);
        add_row("lu_rs1",    32'h003100b3, 8'hc2, EX_NOP, RES_NOP, 0, 0, 0, 5'd0, 5'b11001);
        add_row("lu_rs1_go", 32'h003100b3, 8'h00, EX_ADD, RES_ARITH, rf(2), rf(3), 0,
                5'd1, 5'b11110);
        add_row("lu_rs2",    32'h003100b3, 8'hc3, EX_NOP, RES_NOP, 0, 0, 0, 5'd0, 5'b11001);
        add_row("lu_rs2_go", 32'h003100b3, 8'h00, EX_ADD, RES_ARITH, rf(2), rf(3), 0,
                5'd1, 5'b11110);
        add_row("unknown",   32'h0000007f, 8'h00, EX_NOP, RES_NOP, 0, 0, 0, 5'd0, 5'b00000);
    endtask

    task automatic drive_fwd(input logic [7:0] fwd);
        ex_ld_flag_i = fwd[7];
        ex_wreg_i    = fwd[6];
        mem_wreg_i   = fwd[5];
        ex_wd_i      = fwd[4:0];
        mem_wd_i     = fwd[4:0];
        ex_wdata_i   = EXD;
        mem_wdata_i  = MEMD;
    endtask

    task automatic check_field(input string name, input string field,
                               input word_t exp, input word_t act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    // ======================================================================
    // main sequence, two cycles per row
    // ======================================================================
    initial begin
        row_t r;
        reset_i = 1'b1;
        inst_i  = NOP_INST;
        drive_fwd(8'h00);
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        foreach (rows[i]) begin
            r = rows[i];
            inst_i = r.inst;
            drive_fwd(8'h00);
            @(negedge clk);
            drive_fwd(r.fwd);             // word is buffered now.
            inst_i = NOP_INST;            // next word, ignored while stalled.
            #1;
            check_field(names[i], "stall", 32'(r.flags[0]), 32'(stall_req_o));
            check_field(names[i], "rd1", 32'(r.flags[4]), 32'(reg1_read));
            check_field(names[i], "rd2", 32'(r.flags[3]), 32'(reg2_read));
            @(negedge clk);
            check_field(names[i], "aluop", 32'(r.op), 32'(ex_aluop_o));
            check_field(names[i], "alusel", 32'(r.sel), 32'(ex_alusel_o));
            check_field(names[i], "reg1", r.r1, ex_reg1_o);
            check_field(names[i], "reg2", r.r2, ex_reg2_o);
            check_field(names[i], "offset", r.off, ex_offset_o);
            check_field(names[i], "wd", 32'(r.wd), 32'(ex_wd_o));
            check_field(names[i], "wreg", 32'(r.flags[2]), 32'(ex_wreg_o));
            check_field(names[i], "valid", 32'(r.flags[1]), 32'(ex_inst_valid_o));
            if (r.flags[0]) begin
                // a stalled word stays in the buffer.
                check_field(names[i], "held stall", 32'(1'b1), 32'(stall_req_o));
                check_field(names[i], "held rd1", 32'(r.flags[4]), 32'(reg1_read));
                check_field(names[i], "held rd2", 32'(r.flags[3]), 32'(reg2_read));
            end
        end
        drive_fwd(8'h00);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog, four cycles per row plus reset.
    initial begin
        int limit;
        #1;
        limit = (rows.size() * 4 + RESET_CYCLES + 4) * CLK_PERIOD;
        #(limit);
        $display("watchdog timeout, table not finished after %0d ns", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule
